/* rtl/mips_pkg.sv */
// ##########################################################
// shared types and encodings for the five-stage mips core
// opcodes, funct codes, alu operations and field positions
// ##########################################################
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b,
        op_beq   = 6'h04,
        op_bne   = 6'h05
    } opcode_e;

    typedef enum logic [5:0] {
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_e;

    localparam int    ROM_DEPTH = 64;             // instruction words
    localparam word_t NOP_WORD  = 32'h0000_0000;  // rtype with unknown funct
    localparam word_t PC_STEP   = 32'd4;

    localparam int OPC_LSB   = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int IMM_WIDTH = 16;

endpackage

/* rtl/control_unit.sv */
// ##########################################################
// main decoder, opcode and funct to strobes and alu op
// ##########################################################
module control_unit (
    input  mips_pkg::opcode_e opcode,
    input  mips_pkg::funct_e  funct,
    output logic              reg_write,
    output logic              dest_rd,
    output logic              alu_src_imm,
    output logic              mem_read,
    output logic              mem_write,
    output logic              is_beq,
    output logic              is_bne,
    output mips_pkg::alu_op_e alu_op
);
    import mips_pkg::*;

    always_comb
    begin
        reg_write   = 1'b0;
        dest_rd     = 1'b0;
        alu_src_imm = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        is_beq      = 1'b0;
        is_bne      = 1'b0;
        alu_op      = alu_add;
        case (opcode)
            op_rtype:
            begin
                reg_write = 1'b1;
                dest_rd   = 1'b1;
                case (funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    default:
                    begin
                        reg_write = 1'b0;                // covers the all-zero nop
                        dest_rd   = 1'b0;
                    end
                endcase
            end
            op_addi:
            begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            op_lw:
            begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;                      // base plus offset
                mem_read    = 1'b1;
            end
            op_sw:
            begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            op_beq:  is_beq = 1'b1;
            op_bne:  is_bne = 1'b1;
            default: alu_op = alu_add;
        endcase
    end

endmodule

/* rtl/fetch_stage.sv */
// ##########################################################
// fetch stage, program counter and instruction rom
// ##########################################################
module fetch_stage (
    input  logic            SYS_clk,
    input  logic            SYS_reset,
    input  logic            stall,
    input  logic            take_branch,
    input  mips_pkg::word_t branch_target,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t instr
);
    import mips_pkg::*;

    word_t rom [ROM_DEPTH];
    word_t pc_next;

    initial
    begin
        for (int i = 0; i < ROM_DEPTH; i++)
            rom[i] = NOP_WORD;                           // words past the program run as nops
        $readmemh("verification/program.hex", rom);
    end

    always_comb
    begin
        if (stall)
            pc_next = pc;                                // decode holding, refetch same word
        else if (take_branch)
            pc_next = branch_target;
        else
            pc_next = pc + PC_STEP;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= '0;
        else
            pc <= pc_next;
    end

    assign instr = rom[pc[$clog2(ROM_DEPTH)+1:2]];       // word index, byte bits dropped

endmodule

/* rtl/hazard_unit.sv */
// ##########################################################
// hazard unit, stall counter and memory to decode forwarding
// ##########################################################
module hazard_unit (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::word_t     d_instr,
    input  mips_pkg::reg_addr_t ex_dest,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  mips_pkg::reg_addr_t mem_dest,
    input  logic                mem_reg_write,
    input  logic                mem_mem_read,
    output logic                stall,
    output logic                fwd_rs,
    output logic                fwd_rt
);
    import mips_pkg::*;

    opcode_e   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      uses_rs;
    logic      uses_rt;
    logic      ex_hit;
    logic      mem_rs_hit;
    logic      mem_rt_hit;
    logic [1:0] need;                                    // stalls wanted by a fresh hazard
    logic [1:0] stall_count;

    function automatic logic src_match(reg_addr_t dst, logic we, logic used, reg_addr_t src);
        return we && used && (dst != '0) && (dst == src);
    endfunction

    assign opcode = opcode_e'(d_instr[OPC_LSB +: $bits(opcode_e)]);
    assign rs     = d_instr[RS_LSB +: $bits(reg_addr_t)];
    assign rt     = d_instr[RT_LSB +: $bits(reg_addr_t)];

    always_comb
    begin
        uses_rs = 1'b0;
        uses_rt = 1'b0;
        case (opcode)
            op_rtype, op_sw, op_beq, op_bne:
            begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;                          // store data counts as a source
            end
            op_addi, op_lw: uses_rs = 1'b1;
            default:        uses_rs = 1'b0;
        endcase
    end

    assign ex_hit     = src_match(ex_dest, ex_reg_write, uses_rs, rs)
                      || src_match(ex_dest, ex_reg_write, uses_rt, rt);
    assign mem_rs_hit = src_match(mem_dest, mem_reg_write, uses_rs, rs);
    assign mem_rt_hit = src_match(mem_dest, mem_reg_write, uses_rt, rt);

    always_comb
    begin
        if (ex_hit && ex_mem_read)
            need = 2'd2;                                 // wait until the load reaches writeback
        else if (ex_hit || (mem_mem_read && (mem_rs_hit || mem_rt_hit)))
            need = 2'd1;
        else
            need = 2'd0;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            stall_count <= 2'd0;
        else if (stall_count != 2'd0)
            stall_count <= stall_count - 2'd1;
        else if (need != 2'd0)
            stall_count <= need - 2'd1;                  // this cycle already stalls
    end

    assign stall  = (stall_count != 2'd0) || (need != 2'd0);
    assign fwd_rs = mem_rs_hit && !mem_mem_read;         // alu result only, loads have no data yet
    assign fwd_rt = mem_rt_hit && !mem_mem_read;

endmodule

/* rtl/decode_stage.sv */
// ##########################################################
// decode stage, register file with write bypass,
// operand forwarding and branch resolution
// ##########################################################
module decode_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                stall,
    input  mips_pkg::word_t     instr,
    input  mips_pkg::word_t     pc,
    input  logic                wb_reg_write,
    input  mips_pkg::reg_addr_t wb_dest,
    input  mips_pkg::word_t     wb_data,
    input  logic                fwd_rs,
    input  logic                fwd_rt,
    input  mips_pkg::word_t     mem_fwd_data,
    output mips_pkg::word_t     d_instr,
    output logic                take_branch,
    output mips_pkg::word_t     branch_target,
    output logic                reg_write,
    output logic                mem_read,
    output logic                mem_write,
    output logic                alu_src_imm,
    output mips_pkg::alu_op_e   alu_op,
    output mips_pkg::word_t     rs_val,
    output mips_pkg::word_t     rt_val,
    output mips_pkg::word_t     imm,
    output mips_pkg::reg_addr_t dest
);
    import mips_pkg::*;

    word_t     regs [32];
    word_t     d_pc;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     rs_rf;
    word_t     rt_rf;
    logic      dest_rd;
    logic      is_beq;
    logic      is_bne;
    logic      operands_eq;

    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (wb_reg_write && (wb_dest == addr))
            return wb_data;                              // same-cycle writeback passes through
        else
            return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            d_instr <= NOP_WORD;
        else if (!stall)
            d_instr <= instr;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
            d_pc <= pc;                                  // branch target base
    end

    always_ff @(posedge SYS_clk)
    begin
        if (wb_reg_write && (wb_dest != '0))
            regs[wb_dest] <= wb_data;
    end

    assign rs = d_instr[RS_LSB +: $bits(reg_addr_t)];
    assign rt = d_instr[RT_LSB +: $bits(reg_addr_t)];
    assign rd = d_instr[RD_LSB +: $bits(reg_addr_t)];

    always_comb
    begin
        rs_rf = read_port(rs);
        rt_rf = read_port(rt);
    end

    control_unit control_unit_i (
        .opcode      (opcode_e'(d_instr[OPC_LSB +: $bits(opcode_e)])),
        .funct       (funct_e'(d_instr[$bits(funct_e)-1:0])),
        .reg_write   (reg_write),
        .dest_rd     (dest_rd),
        .alu_src_imm (alu_src_imm),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .is_beq      (is_beq),
        .is_bne      (is_bne),
        .alu_op      (alu_op)
    );

    assign rs_val      = fwd_rs ? mem_fwd_data : rs_rf;
    assign rt_val      = fwd_rt ? mem_fwd_data : rt_rf;
    assign imm         = {{($bits(word_t)-IMM_WIDTH){d_instr[IMM_WIDTH-1]}},
                          d_instr[IMM_WIDTH-1:0]};
    assign dest        = dest_rd ? rd : rt;             // rd for rtype, rt for immediates
    assign operands_eq = (rs_val == rt_val);

    assign take_branch   = !stall && ((is_beq && operands_eq) || (is_bne && !operands_eq));
    assign branch_target = d_pc + PC_STEP + (imm << 2);

endmodule

/* rtl/execute_stage.sv */
// ##########################################################
// execute stage, id/ex register with bubble insert and alu
// ##########################################################
module execute_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                stall,
    input  mips_pkg::word_t     d_instr,
    input  logic                reg_write,
    input  logic                mem_read,
    input  logic                mem_write,
    input  logic                alu_src_imm,
    input  mips_pkg::alu_op_e   alu_op,
    input  mips_pkg::word_t     rs_val,
    input  mips_pkg::word_t     rt_val,
    input  mips_pkg::word_t     imm,
    input  mips_pkg::reg_addr_t dest,
    output mips_pkg::word_t     ex_instr,
    output logic                ex_reg_write,
    output logic                ex_mem_read,
    output logic                ex_mem_write,
    output mips_pkg::reg_addr_t ex_dest,
    output mips_pkg::word_t     alu_result,
    output mips_pkg::word_t     store_data
);
    import mips_pkg::*;

    logic    ex_alu_src_imm;
    alu_op_e ex_alu_op;
    word_t   ex_rs_val;
    word_t   ex_rt_val;
    word_t   ex_imm;
    word_t   alu_b;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
        begin
            ex_instr       <= NOP_WORD;                  // bubble
            ex_reg_write   <= 1'b0;
            ex_mem_read    <= 1'b0;
            ex_mem_write   <= 1'b0;
            ex_alu_src_imm <= 1'b0;
        end
        else
        begin
            ex_instr       <= d_instr;
            ex_reg_write   <= reg_write;
            ex_mem_read    <= mem_read;
            ex_mem_write   <= mem_write;
            ex_alu_src_imm <= alu_src_imm;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_alu_op <= alu_op;
        ex_rs_val <= rs_val;
        ex_rt_val <= rt_val;
        ex_imm    <= imm;
        ex_dest   <= dest;
    end

    assign alu_b = ex_alu_src_imm ? ex_imm : ex_rt_val;

    always_comb
    begin
        case (ex_alu_op)
            alu_add: alu_result = ex_rs_val + alu_b;
            alu_sub: alu_result = ex_rs_val - alu_b;
            alu_and: alu_result = ex_rs_val & alu_b;
            alu_or:  alu_result = ex_rs_val | alu_b;
            alu_slt: alu_result = {31'd0, $signed(ex_rs_val) < $signed(alu_b)};
            default: alu_result = '0;
        endcase
    end

    assign store_data = ex_rt_val;                       // sw data from rt

endmodule

/* rtl/mem_wb_stages.sv */
// ##########################################################
// memory and writeback registers, data bus, writeback select
// ##########################################################
module mem_wb_stages (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  logic                ex_reg_write,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  mips_pkg::reg_addr_t ex_dest,
    input  mips_pkg::word_t     alu_result,
    input  mips_pkg::word_t     store_data,
    output mips_pkg::word_t     dmem_addr,
    output mips_pkg::word_t     dmem_wdata,
    output logic                dmem_we,
    output logic                dmem_re,
    input  mips_pkg::word_t     dmem_rdata,
    output mips_pkg::reg_addr_t mem_dest,
    output logic                mem_reg_write,
    output logic                mem_mem_read,
    output mips_pkg::word_t     mem_fwd_data,
    output logic                wb_reg_write,
    output mips_pkg::reg_addr_t wb_dest,
    output mips_pkg::word_t     wb_data
);
    import mips_pkg::*;

    logic  mem_mem_write;
    word_t mem_alu_result;
    word_t mem_store_data;
    logic  wb_mem_read;
    word_t wb_alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
            wb_reg_write  <= 1'b0;
            wb_mem_read   <= 1'b0;
        end
        else
        begin
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
            wb_reg_write  <= mem_reg_write;
            wb_mem_read   <= mem_mem_read;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_dest       <= ex_dest;
        mem_alu_result <= alu_result;
        mem_store_data <= store_data;
        wb_dest        <= mem_dest;
        wb_alu_result  <= mem_alu_result;
    end

    assign dmem_addr    = mem_alu_result;
    assign dmem_wdata   = mem_store_data;
    assign dmem_we      = mem_mem_write;                 // one cycle per sw
    assign dmem_re      = mem_mem_read;
    assign mem_fwd_data = mem_alu_result;

    assign wb_data = wb_mem_read ? dmem_rdata : wb_alu_result;  // read data valid this cycle

endmodule

/* rtl/mips_pipeline.sv */
// ##########################################################
// five-stage mips pipeline top, stages and hazard unit
// ##########################################################
module mips_pipeline (
    input  logic            SYS_clk,
    input  logic            SYS_reset,
    output mips_pkg::word_t dmem_addr,
    output mips_pkg::word_t dmem_wdata,
    output logic            dmem_we,
    output logic            dmem_re,
    input  mips_pkg::word_t dmem_rdata
);
    import mips_pkg::*;

    word_t     pc;
    word_t     instr;
    logic      stall;
    logic      take_branch;
    word_t     branch_target;
    word_t     d_instr;
    logic      d_reg_write;
    logic      d_mem_read;
    logic      d_mem_write;
    logic      d_alu_src_imm;
    alu_op_e   d_alu_op;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm;
    reg_addr_t d_dest;
    logic      fwd_rs;
    logic      fwd_rt;
    logic      ex_reg_write;
    logic      ex_mem_read;
    logic      ex_mem_write;
    reg_addr_t ex_dest;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t mem_dest;
    logic      mem_reg_write;
    logic      mem_mem_read;
    word_t     mem_fwd_data;
    logic      wb_reg_write;
    reg_addr_t wb_dest;
    word_t     wb_data;

    fetch_stage fetch_stage_i (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .pc            (pc),
        .instr         (instr)
    );

    decode_stage decode_stage_i (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .stall         (stall),
        .instr         (instr),
        .pc            (pc),
        .wb_reg_write  (wb_reg_write),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt),
        .mem_fwd_data  (mem_fwd_data),
        .d_instr       (d_instr),
        .take_branch   (take_branch),
        .branch_target (branch_target),
        .reg_write     (d_reg_write),
        .mem_read      (d_mem_read),
        .mem_write     (d_mem_write),
        .alu_src_imm   (d_alu_src_imm),
        .alu_op        (d_alu_op),
        .rs_val        (rs_val),
        .rt_val        (rt_val),
        .imm           (imm),
        .dest          (d_dest)
    );

    hazard_unit hazard_unit_i (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .d_instr       (d_instr),
        .ex_dest       (ex_dest),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .mem_mem_read  (mem_mem_read),
        .stall         (stall),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt)
    );

    execute_stage execute_stage_i (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .stall        (stall),
        .d_instr      (d_instr),
        .reg_write    (d_reg_write),
        .mem_read     (d_mem_read),
        .mem_write    (d_mem_write),
        .alu_src_imm  (d_alu_src_imm),
        .alu_op       (d_alu_op),
        .rs_val       (rs_val),
        .rt_val       (rt_val),
        .imm          (imm),
        .dest         (d_dest),
        .ex_instr     (),
        .ex_reg_write (ex_reg_write),
        .ex_mem_read  (ex_mem_read),
        .ex_mem_write (ex_mem_write),
        .ex_dest      (ex_dest),
        .alu_result   (alu_result),
        .store_data   (store_data)
    );

    mem_wb_stages mem_wb_stages_i (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_dest       (ex_dest),
        .alu_result    (alu_result),
        .store_data    (store_data),
        .dmem_addr     (dmem_addr),
        .dmem_wdata    (dmem_wdata),
        .dmem_we       (dmem_we),
        .dmem_re       (dmem_re),
        .dmem_rdata    (dmem_rdata),
        .mem_dest      (mem_dest),
        .mem_reg_write (mem_reg_write),
        .mem_mem_read  (mem_mem_read),
        .mem_fwd_data  (mem_fwd_data),
        .wb_reg_write  (wb_reg_write),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data)
    );

endmodule

/* verification/mips_assertions.sv */
// ##########################################################
// bound checks on the data bus of the mips pipeline
// ##########################################################
module mips_assertions (
    input logic            SYS_clk,
    input logic            SYS_reset,
    input mips_pkg::word_t dmem_addr,
    input logic            dmem_we,
    input logic            dmem_re
);
    int fail_count = 0;                                  // watched by the testbench

    bus_exclusive: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(dmem_we && dmem_re))
    else
    begin
        $error("data bus read and write strobes are high in the same cycle");
        fail_count++;
    end

    bus_aligned: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (dmem_we || dmem_re) |-> (dmem_addr[1:0] == 2'b00))
    else
    begin
        $error("data bus address is not word aligned");
        fail_count++;
    end

    // strobes must come out of reset low
    quiet_after_reset: assert property (@(posedge SYS_clk)
        SYS_reset |=> (!dmem_we && !dmem_re))
    else
    begin
        $error("data bus strobe active right after reset");
        fail_count++;
    end

endmodule

bind mips_pipeline mips_assertions mips_assertions_i (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .dmem_addr (dmem_addr),
    .dmem_we   (dmem_we),
    .dmem_re   (dmem_re)
);

/* verification/tb_mips.sv */
// ##########################################################
// testbench for the mips pipeline, data memory model,
// expected store table and cycle limit
// ##########################################################
module tb_mips;
    import mips_pkg::*;

    localparam int MEM_WORDS    = 64;
    localparam int LOAD_WORD    = 32;                    // lw 128($0)
    localparam int DRAIN_CYCLES = 8;                     // room for a stray late store
    localparam int MAX_CYCLES   = 200;                   // about 45 with stalls plus margin

    logic  SYS_clk    = 1'b0;
    logic  SYS_reset  = 1'b1;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    logic  dmem_re;
    word_t dmem_rdata = '0;

    word_t data_mem [MEM_WORDS];
    word_t init_mem [MEM_WORDS];
    word_t exp_addr [$];
    word_t exp_data [$];
    string exp_name [$];
    int    store_idx   = 0;
    int    cycle_count = 0;

    mips_pipeline mips_pipeline_i (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata)
    );

    always #20 SYS_clk = ~SYS_clk;

    function automatic word_t xorshift32(input word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic fill_memory();
        word_t state;
        state = 32'd46952;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            state       = xorshift32(state);
            init_mem[i] = state;
        end
    endtask

    task automatic expect_store(input word_t addr, input word_t data, input string name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_name.push_back(name);
    endtask

    // register values follow the program one instruction at a time
    task automatic build_expected();
        word_t r1, r2, r3, r4, r5, r6, r7, r9;
        r1 = 32'd25;
        r2 = r1 - 32'd7;                                 // addi with -7
        r3 = r1 + r2;
        r4 = r2 - r1;
        r5 = r3 & r2;
        r6 = r3 | r4;
        r7 = ($signed(r4) < $signed(r1)) ? 32'd1 : 32'd0;
        r9 = init_mem[LOAD_WORD] + 32'd100;              // loaded word plus immediate
        expect_store(32'd16, r7, "slt stored by the next sw");
        expect_store(32'd0,  r3, "add");
        expect_store(32'd4,  r4, "sub");
        expect_store(32'd8,  r5, "and");
        expect_store(32'd12, r6, "or");
        expect_store(32'd20, r9, "load-use addi");
        expect_store(32'd24, r2, "beq delay slot");
        expect_store(32'd32, r1, "bne delay slot");
        expect_store(32'd36, r9, "bne fall-through");
    endtask

    always @(posedge SYS_clk)
    begin
        if (SYS_reset)
            data_mem <= init_mem;
        else
        begin
            if (dmem_we)
                data_mem[dmem_addr[7:2]] <= dmem_wdata;
            if (dmem_re)
                dmem_rdata <= data_mem[dmem_addr[7:2]];  // valid through the next cycle
        end
    end

    always @(posedge SYS_clk)
    begin
        if (!SYS_reset && dmem_we)
        begin
            assert (store_idx < exp_addr.size())
            else fail_run($sformatf("unexpected extra store to address %h", dmem_addr));
            assert (dmem_addr == exp_addr[store_idx])
            else fail_run($sformatf("Mismatch in %s address: expected %h, actual %h",
                                    exp_name[store_idx], exp_addr[store_idx], dmem_addr));
            assert (dmem_wdata == exp_data[store_idx])
            else fail_run($sformatf("Mismatch in %s data: expected %h, actual %h",
                                    exp_name[store_idx], exp_data[store_idx], dmem_wdata));
            store_idx <= store_idx + 1;
        end
    end

    always @(posedge SYS_clk)
    begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < MAX_CYCLES)
        else fail_run($sformatf("run reached the %0d cycle limit before all stores were seen",
                                MAX_CYCLES));
        assert (mips_pipeline_i.mips_assertions_i.fail_count == 0)
        else fail_run("a bound data bus assertion failed");
    end

    initial
    begin
        fill_memory();
        build_expected();
        repeat (4) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
        wait (store_idx == exp_addr.size());
        repeat (DRAIN_CYCLES) @(posedge SYS_clk);
        $display("Everything OK");
        $finish;
    end

endmodule

/* flist.f */
rtl/mips_pkg.sv
rtl/control_unit.sv
rtl/fetch_stage.sv
rtl/hazard_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stages.sv
rtl/mips_pipeline.sv
verification/mips_assertions.sv
verification/tb_mips.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 --top-module tb_mips -f flist.f &&
./obj_dir/Vtb_mips +verilator+error+limit+100 | tee /dev/stderr | grep -q "Everything OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* verification/program.hex */
// one 32-bit instruction word per line in hex, first line at pc 0
// the comment after each word gives its assembly
20010019 // addi $1, $0, 25
2022FFF9 // addi $2, $1, -7
00221820 // add  $3, $1, $2
00412022 // sub  $4, $2, $1
00622824 // and  $5, $3, $2
00643025 // or   $6, $3, $4
0081382A // slt  $7, $4, $1
AC070010 // sw   $7, 16($0)
AC030000 // sw   $3, 0($0)
AC040004 // sw   $4, 4($0)
AC050008 // sw   $5, 8($0)
AC06000C // sw   $6, 12($0)
8C080080 // lw   $8, 128($0)
21090064 // addi $9, $8, 100
AC090014 // sw   $9, 20($0)
10210002 // beq  $1, $1, 2
AC020018 // sw   $2, 24($0)
AC03001C // sw   $3, 28($0)
14420005 // bne  $2, $2, 5
AC010020 // sw   $1, 32($0)
AC090024 // sw   $9, 36($0)
1000FFFF // beq  $0, $0, -1
00000000 // nop
